//--- design/clkgen_macros.svh
`ifndef CLKGEN_MACROS_SVH
`define CLKGEN_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// machine cycles counted by the divider
`define DIV_WIDTH 16

// io address of the DIV register
`define DIV_ADDR 16'hFF04

// count bit whose falling edge steps the frame clock (512 Hz)
`define FRAME_TAP 10

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// master clocks per machine cycle
`define PHASE_COUNT 4

`endif

//--- design/clkgen_pkg.sv
`include "clkgen_macros.svh"

package clkgen_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// cpu side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic [15:0] addr;
		logic        wr;    // io write, sampled every cycle
	} cpu_bus_t;

	typedef struct packed {
		logic [1:0] index;      // 0..3 within the machine cycle
		logic       mcycle_en;  // one clock per machine cycle, at index 3
		logic       cpu_clk;    // high in phases 0 and 1
		logic       rd_sync;
		logic       wr_sync;
	} phase_t;

	typedef struct packed {
		logic sys_reset;
		logic video_reset;
		logic div_clear_pending;
	} reset_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// divider and its consumers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic hz_262144;
		logic hz_65536;
		logic hz_16384;
		logic hz_4096;
	} timer_taps_t;

	typedef struct packed {
		logic hz_512;
		logic hz_256;
		logic hz_128;
		logic frame_step;
		logic en_2m;
		logic en_1m;
		logic en_512k;
	} frame_clk_t;

	// register view of the divider, DIV is count[13:6]
	typedef struct packed {
		logic [1:0] upper;
		logic [7:0] div_reg;
		logic [5:0] prescale;
	} div_fields_t;

	typedef union packed {
		logic [`DIV_WIDTH-1:0] count;
		div_fields_t           fields;
	} div_word_u;

endpackage

//--- design/phase_sequencer.sv
`timescale 1ns/1ps
`include "clkgen_macros.svh"

module phase_sequencer (
	input  logic                clkin_a,
	input  logic                reset,
	output clkgen_pkg::phase_t  phase
);

	import clkgen_pkg::*;

	localparam int LAST_PHASE = `PHASE_COUNT - 1;

	phase_t     phase_q;
	logic [1:0] index_next;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// phase counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		if (phase_q.index == 2'(LAST_PHASE)) begin
			index_next = 2'd0;  // wrap into the next machine cycle
		end else begin
			index_next = phase_q.index + 2'd1;
		end
	end

	// strobes are decoded from the next index and registered,
	// so every output comes straight off a flop
	always_ff @(posedge clkin_a) begin
		if (reset) begin
			phase_q <= '0;
		end else begin
			phase_q.index     <= index_next;
			phase_q.mcycle_en <= (index_next == 2'(LAST_PHASE));
			phase_q.cpu_clk   <= (index_next < 2'd2);          // phases 0 and 1
			phase_q.rd_sync   <= (index_next == 2'd1);
			phase_q.wr_sync   <= (index_next == 2'(LAST_PHASE));
		end
	end

	assign phase = phase_q;

endmodule

//--- design/reset_control.sv
`timescale 1ns/1ps

module reset_control (
	input  logic                clkin_a,
	input  logic                reset,
	input  logic                mcycle_en,
	input  logic                lcd_enable,
	input  logic                div_write,
	output clkgen_pkg::reset_t  resets
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// system and video reset
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// sys_reset is stretched to the end of the first machine cycle,
	// like the old power-on latch released on a cpu clock edge
	always_ff @(posedge clkin_a) begin
		if (reset) begin
			resets.sys_reset <= 1'b1;
		end else if (mcycle_en) begin
			resets.sys_reset <= 1'b0;
		end
	end

	always_ff @(posedge clkin_a) begin
		if (reset) begin
			resets.video_reset <= 1'b1;
		end else begin
			resets.video_reset <= resets.sys_reset | ~lcd_enable;  // lcdc.7 off holds ppu
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// divider clear request
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a new write wins over the machine cycle that would consume
	// an older request
	always_ff @(posedge clkin_a) begin
		if (reset) begin
			resets.div_clear_pending <= 1'b0;
		end else if (div_write) begin
			resets.div_clear_pending <= 1'b1;
		end else if (mcycle_en) begin
			resets.div_clear_pending <= 1'b0;  // divider took it
		end
	end

endmodule

//--- design/div_counter.sv
`timescale 1ns/1ps
`include "clkgen_macros.svh"

module div_counter (
	input  logic                     clkin_a,
	input  logic                     reset,
	input  clkgen_pkg::cpu_bus_t     bus,
	input  logic                     rd,
	input  logic                     mcycle_en,
	input  logic                     sys_reset,
	input  logic                     div_clear,
	output logic                     div_write,
	output clkgen_pkg::div_word_u    div_word,
	output logic [7:0]               rd_data,
	output logic                     rd_valid,
	output clkgen_pkg::timer_taps_t  taps
);

	logic                   div_sel;
	logic [`DIV_WIDTH-1:0]  count_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign div_sel   = (bus.addr == `DIV_ADDR);
	assign div_write = div_sel & bus.wr;  // any value written clears
	assign rd_valid  = div_sel & rd;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// machine cycle counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clkin_a) begin
		if (reset) begin
			count_q <= '0;
		end else if (sys_reset) begin
			count_q <= '0;  // starts counting with the first free machine cycle
		end else if (mcycle_en) begin
			if (div_clear) begin
				count_q <= '0;
			end else begin
				count_q <= count_q + `DIV_WIDTH'(1);
			end
		end
	end

	assign div_word.count = count_q;

	// the cpu sees the register view, the rest of the chip raw bits
	assign rd_data = div_word.fields.div_reg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// timer taps
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clkin_a) begin
		if (reset) begin
			taps <= '0;
		end else begin
			taps.hz_262144 <= div_word.count[1];
			taps.hz_65536  <= div_word.count[3];
			taps.hz_16384  <= div_word.count[5];
			taps.hz_4096   <= div_word.count[7];
		end
	end

endmodule

//--- design/apu_clock_gen.sv
`timescale 1ns/1ps
`include "clkgen_macros.svh"

module apu_clock_gen (
	input  logic                    clkin_a,
	input  logic                    reset,
	input  logic                    sys_reset,
	input  logic                    apu_reset,
	input  logic                    frame_test,
	input  clkgen_pkg::div_word_u   div_word,
	output clkgen_pkg::frame_clk_t  frame
);

	logic       apu_hold;
	logic [2:0] apu_div;
	logic       en_2m;
	logic       en_1m;
	logic       en_512k;
	logic       tap_q;
	logic       tap_fall;
	logic       step_src;
	logic       frame_step_q;
	logic [2:0] frame_cnt;

	assign apu_hold = apu_reset | sys_reset;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// apu clock enables
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clkin_a) begin
		if (reset || apu_hold) begin
			apu_div <= '0;
		end else begin
			apu_div <= apu_div + 3'd1;
		end
	end

	assign en_2m   = apu_div[0];
	assign en_1m   = &apu_div[1:0];
	assign en_512k = &apu_div;  // once every 8 clocks

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame sequencer clock
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clkin_a) begin
		if (reset) begin
			tap_q <= 1'b0;
		end else begin
			tap_q <= div_word.count[`FRAME_TAP];
		end
	end

	assign tap_fall = tap_q & ~div_word.count[`FRAME_TAP];
	assign step_src = frame_test ? en_512k : tap_fall;  // fero test speeds it up

	always_ff @(posedge clkin_a) begin
		if (reset || apu_hold) begin
			frame_step_q <= 1'b0;
			frame_cnt    <= '0;
		end else begin
			frame_step_q <= step_src;
			if (step_src) begin
				frame_cnt <= frame_cnt + 3'd1;
			end
		end
	end

	assign frame.hz_512     = frame_cnt[0];
	assign frame.hz_256     = frame_cnt[1];
	assign frame.hz_128     = frame_cnt[2];
	assign frame.frame_step = frame_step_q;
	assign frame.en_2m      = en_2m;
	assign frame.en_1m      = en_1m;
	assign frame.en_512k    = en_512k;

endmodule

//--- design/clocks_reset.sv
`timescale 1ns/1ps

module clocks_reset (
	input  logic                     clkin_a,
	input  logic                     reset,
	input  clkgen_pkg::cpu_bus_t     bus,
	input  logic                     rd,
	input  logic                     lcd_enable,
	input  logic                     apu_reset,
	input  logic                     frame_test,
	output clkgen_pkg::phase_t       phase,
	output clkgen_pkg::reset_t       resets,
	output logic [7:0]               rd_data,
	output logic                     rd_valid,
	output clkgen_pkg::timer_taps_t  taps,
	output clkgen_pkg::frame_clk_t   frame
);

	import clkgen_pkg::*;

	logic      div_write;
	div_word_u div_word;

	phase_sequencer phase_sequencer_i (
		.clkin_a (clkin_a),
		.reset   (reset),
		.phase   (phase)
	);

	reset_control reset_control_i (
		.clkin_a    (clkin_a),
		.reset      (reset),
		.mcycle_en  (phase.mcycle_en),
		.lcd_enable (lcd_enable),
		.div_write  (div_write),
		.resets     (resets)
	);

	div_counter div_counter_i (
		.clkin_a   (clkin_a),
		.reset     (reset),
		.bus       (bus),
		.rd        (rd),
		.mcycle_en (phase.mcycle_en),
		.sys_reset (resets.sys_reset),
		.div_clear (resets.div_clear_pending),
		.div_write (div_write),
		.div_word  (div_word),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.taps      (taps)
	);

	apu_clock_gen apu_clock_gen_i (
		.clkin_a    (clkin_a),
		.reset      (reset),
		.sys_reset  (resets.sys_reset),
		.apu_reset  (apu_reset),
		.frame_test (frame_test),
		.div_word   (div_word),
		.frame      (frame)
	);

endmodule

//--- bench/clocks_reset_checker.sv
`timescale 1ns/1ps

module clocks_reset_checker (
	input logic                    clkin_a,
	input logic                    reset,
	input clkgen_pkg::phase_t      phase,
	input logic                    rd,
	input logic                    rd_valid,
	input logic                    apu_reset,
	input clkgen_pkg::frame_clk_t  frame
);

	import clkgen_pkg::*;

	logic apu_en_any;
	int   fail_count = 0;

	assign apu_en_any = frame.en_2m | frame.en_1m | frame.en_512k;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// strobe and reset rules
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	mcycle_one_in_four: assert property (@(posedge clkin_a) disable iff (reset)
		phase.mcycle_en |=> !phase.mcycle_en [*3] ##1 phase.mcycle_en)
		else begin
			fail_count++;
			$error("mcycle_en is not one clock in four");
		end

	rd_valid_needs_rd: assert property (@(posedge clkin_a) disable iff (reset)
		rd_valid |-> rd)
		else begin
			fail_count++;
			$error("rd_valid high without rd");
		end

	// the apu divider clears on the first edge that sees apu_reset
	apu_quiet_in_reset: assert property (@(posedge clkin_a) disable iff (reset)
		apu_reset |=> !apu_en_any)
		else begin
			fail_count++;
			$error("apu clock enable fired during apu_reset");
		end

endmodule

bind clocks_reset clocks_reset_checker checker_i (
	.clkin_a   (clkin_a),
	.reset     (reset),
	.phase     (phase),
	.rd        (rd),
	.rd_valid  (rd_valid),
	.apu_reset (apu_reset),
	.frame     (frame)
);

//--- bench/clocks_reset_tb.sv
`timescale 1ns/1ps
`include "clkgen_macros.svh"

module clocks_reset_tb;

	import clkgen_pkg::*;

	localparam int TEST_CYCLES = 25000;  // rough sum over all tests
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

	logic        clkin_a;
	logic        reset;
	cpu_bus_t    bus;
	logic        rd;
	logic        lcd_enable;
	logic        apu_reset;
	logic        frame_test;
	phase_t      phase;
	reset_t      resets;
	logic [7:0]  rd_data;
	logic        rd_valid;
	timer_taps_t taps;
	frame_clk_t  frame;
	int          cycles;
	int          n_checks;
	int          n_errors;
	int          n_assert_fails;

	clocks_reset dut_i (
		.clkin_a    (clkin_a),
		.reset      (reset),
		.bus        (bus),
		.rd         (rd),
		.lcd_enable (lcd_enable),
		.apu_reset  (apu_reset),
		.frame_test (frame_test),
		.phase      (phase),
		.resets     (resets),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid),
		.taps       (taps),
		.frame      (frame)
	);

	initial begin
		clkin_a = 1'b0;
		forever #10 clkin_a = ~clkin_a;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clkin_a);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("TESTS FAILED");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_phase(input phase_t got, input phase_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error: phase got 0x%h expected 0x%h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_resets(input reset_t got, input reset_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error: resets got 0x%h expected 0x%h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_taps(input timer_taps_t got, input timer_taps_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error: taps got 0x%h expected 0x%h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_frame(input frame_clk_t got, input frame_clk_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error: frame got 0x%h expected 0x%h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		n_checks++;
		if (got != exp) begin
			n_errors++;
			$display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic restart();
		@(negedge clkin_a);
		reset = 1'b1;
		repeat (10) @(negedge clkin_a);
		reset = 1'b0;
		do @(negedge clkin_a); while (resets.sys_reset);
	endtask

	// returns on the negedge after the n-th counted machine cycle
	task automatic wait_mcycles(input int n);
		repeat (n) begin
			@(negedge clkin_a);
			while (!phase.mcycle_en) @(negedge clkin_a);
		end
		@(negedge clkin_a);
	endtask

	task automatic read_reg(input logic [15:0] addr, output logic [7:0] data, output logic valid);
		bus.addr = addr;
		rd       = 1'b1;
		#1;
		data  = rd_data;  // combinational read path
		valid = rd_valid;
		@(negedge clkin_a);
		rd       = 1'b0;
		bus.addr = '0;
	endtask

	task automatic measure_toggle(input int t, output int gap);
		logic prev;
		@(negedge clkin_a);
		prev = taps[3-t];
		do @(negedge clkin_a); while (taps[3-t] == prev);
		prev = taps[3-t];
		gap  = 0;
		do begin
			@(negedge clkin_a);
			gap++;
		end while (taps[3-t] == prev);
	endtask

	task automatic wait_frame_step(output int gap);
		gap = 0;
		do begin
			@(negedge clkin_a);
			gap++;
		end while (!frame.frame_step);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_reset_release();
		phase_t exp_ph;
		reset_t exp_rs;
		int     idx;
		@(negedge clkin_a);
		reset = 1'b1;
		repeat (10) @(negedge clkin_a);
		check_phase(phase, '0);
		check_resets(resets, '{sys_reset: 1'b1, video_reset: 1'b1, div_clear_pending: 1'b0});
		check_taps(taps, '0);
		reset = 1'b0;
		for (int k = 1; k <= 12; k++) begin
			@(negedge clkin_a);
			idx                  = k % `PHASE_COUNT;
			exp_ph.index         = 2'(idx);
			exp_ph.mcycle_en     = (idx == 3);
			exp_ph.cpu_clk       = (idx < 2);
			exp_ph.rd_sync       = (idx == 1);
			exp_ph.wr_sync       = (idx == 3);
			exp_rs.sys_reset     = (k < 4);  // drops on the edge after the first mcycle_en
			exp_rs.video_reset   = (k < 5);
			exp_rs.div_clear_pending = 1'b0;
			check_phase(phase, exp_ph);
			check_resets(resets, exp_rs);
		end
	endtask

	task automatic test_div_read();
		int          n;
		logic [15:0] nv;
		logic [7:0]  data;
		logic        valid;
		n  = 600;
		nv = 16'(n);
		restart();
		wait_mcycles(n);
		read_reg(`DIV_ADDR, data, valid);
		check_byte("rd_data", data, nv[13:6]);
		check_byte("rd_valid", 8'(valid), 8'h01);
		read_reg(16'hFF05, data, valid);
		check_byte("rd_valid", 8'(valid), 8'h00);
	endtask

	task automatic test_div_write();
		int          m;
		logic [15:0] mv;
		logic [7:0]  data;
		logic        valid;
		m  = 200 + int'($urandom % 500);
		mv = 16'(m);
		wait_mcycles(100);  // leaves mcycle_en low for the write cycle
		bus.addr = `DIV_ADDR;
		bus.wr   = 1'b1;
		@(negedge clkin_a);
		bus.wr   = 1'b0;
		bus.addr = '0;
		check_resets(resets, '{sys_reset: 1'b0, video_reset: 1'b0, div_clear_pending: 1'b1});
		wait_mcycles(1);
		read_reg(`DIV_ADDR, data, valid);
		check_byte("rd_data", data, 8'h00);
		wait_mcycles(m);
		read_reg(`DIV_ADDR, data, valid);
		check_byte("rd_data", data, mv[13:6]);
	endtask

	task automatic test_taps();
		int          periods[4];
		int          gap;
		logic [15:0] nv;
		timer_taps_t exp;
		periods = '{2, 8, 32, 128};
		nv      = 16'd165;
		restart();
		wait_mcycles(int'(nv));
		@(negedge clkin_a);  // taps trail the count by one clock
		exp = '{hz_262144: nv[1], hz_65536: nv[3], hz_16384: nv[5], hz_4096: nv[7]};
		check_taps(taps, exp);
		for (int t = 0; t < 4; t++) begin
			measure_toggle(t, gap);
			check_count("tap toggle gap", gap, periods[t] * `PHASE_COUNT);
		end
	endtask

	task automatic test_frame();
		int         gap;
		int         last[3];
		int         seen[3];
		int         per[3];
		logic [2:0] en;
		per = '{2, 4, 8};
		restart();
		wait_frame_step(gap);
		check_count("frame counter", int'({frame.hz_128, frame.hz_256, frame.hz_512}), 1);
		wait_frame_step(gap);
		check_count("frame_step gap", gap, 2048 * `PHASE_COUNT);
		check_count("frame counter", int'({frame.hz_128, frame.hz_256, frame.hz_512}), 2);
		frame_test = 1'b1;
		wait_frame_step(gap);
		wait_frame_step(gap);
		check_count("frame_step gap", gap, 8);
		check_count("frame counter", int'({frame.hz_128, frame.hz_256, frame.hz_512}), 4);
		apu_reset = 1'b1;
		repeat (8) begin
			@(negedge clkin_a);
			check_frame(frame, '0);
		end
		apu_reset = 1'b0;
		for (int k = 0; k < 3; k++) begin
			last[k] = -1;
			seen[k] = 0;
		end
		for (int c = 1; c <= 16; c++) begin
			@(negedge clkin_a);
			en = {frame.en_2m, frame.en_1m, frame.en_512k};
			for (int k = 0; k < 3; k++) begin
				if (en[2-k]) begin
					if (last[k] >= 0) check_count("apu enable gap", c - last[k], per[k]);
					last[k] = c;
					seen[k]++;
				end
			end
		end
		for (int k = 0; k < 3; k++) check_count("apu enable pulses", seen[k], 16 / per[k]);
		frame_test = 1'b0;
	endtask

	task automatic test_video_reset();
		@(negedge clkin_a);
		lcd_enable = 1'b0;
		check_resets(resets, '{sys_reset: 1'b0, video_reset: 1'b0, div_clear_pending: 1'b0});
		@(negedge clkin_a);
		check_resets(resets, '{sys_reset: 1'b0, video_reset: 1'b1, div_clear_pending: 1'b0});
		lcd_enable = 1'b1;
		@(negedge clkin_a);
		check_resets(resets, '{sys_reset: 1'b0, video_reset: 1'b0, div_clear_pending: 1'b0});
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		void'($urandom(32'h7cbb_4dc9));
		reset      = 1'b1;
		bus        = '0;
		rd         = 1'b0;
		lcd_enable = 1'b1;
		apu_reset  = 1'b0;
		frame_test = 1'b0;
		n_checks   = 0;
		n_errors   = 0;
		test_reset_release();
		test_div_read();
		test_div_write();
		test_taps();
		test_frame();
		test_video_reset();
		n_assert_fails = dut_i.checker_i.fail_count;
		$display("%0d checks, %0d errors, %0d assertion failures",
			n_checks, n_errors, n_assert_fails);
		if (n_errors == 0 && n_assert_fails == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- clocks_reset.f
+incdir+design
design/clkgen_pkg.sv
design/phase_sequencer.sv
design/reset_control.sv
design/div_counter.sv
design/apu_clock_gen.sv
design/clocks_reset.sv
bench/clocks_reset_checker.sv
bench/clocks_reset_tb.sv

//--- Bender.yml
package:
  name: clocks_reset

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/clkgen_pkg.sv
      - design/phase_sequencer.sv
      - design/reset_control.sv
      - design/div_counter.sv
      - design/apu_clock_gen.sv
      - design/clocks_reset.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/clocks_reset_checker.sv
      - bench/clocks_reset_tb.sv
